//--- files.f
hw/gtiaPkg.sv
hw/playfieldIf.sv
hw/rasterCounter.sv
hw/playfieldSelect.sv
hw/spriteUnit.sv
hw/priorityMixer.sv
hw/gtiaTop.sv
sim/gtiaTb.sv

//--- hw/gtiaPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GTIA pixel path shared definitions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package gtiaPkg;

  // Data and coordinate widths
  localparam int unsigned colorW = 8;
  localparam int unsigned xW = 9;
  localparam int unsigned yW = 8;
  localparam int unsigned addrW = 17;
  localparam int unsigned anW = 4;

  // Display buffer row pitch in words
  localparam int unsigned screenStride = 320;

  // Raster x to sprite horizontal position
  localparam logic [7:0] hPosOffset = 8'h30;

  // Sprite graphics
  localparam int unsigned playerW = 8;
  localparam int unsigned missileW = 2;
  localparam int unsigned numSprites = 4;

  // AN playfield codes, normal mode
  localparam logic [anW-1:0] anIdle = 4'd0;
  localparam logic [anW-1:0] anBackground = 4'd8;
  localparam logic [anW-1:0] anVsync = 4'd9;
  localparam logic [anW-1:0] anHblank = 4'd10;
  localparam logic [anW-1:0] anLum1Col2 = 4'd11;
  localparam logic [anW-1:0] anPlayfield0 = 4'd12;
  localparam logic [anW-1:0] anPlayfield1 = 4'd13;
  localparam logic [anW-1:0] anPlayfield2 = 4'd14;
  localparam logic [anW-1:0] anPlayfield3 = 4'd15;

  // PRIOR register fields
  localparam logic [1:0] modeNormal = 2'd0;
  localparam logic [3:0] prioPfOverLow = 4'd0;
  localparam logic [3:0] prioSpritesFirst = 4'd1;

  // Scan lines per mode line
  localparam logic [1:0] lineSingle = 2'd0;
  localparam logic [1:0] lineDouble = 2'd1;

  // GRAFM seen as one byte or as four missile patterns
  typedef union packed {
    logic [colorW-1:0] raw;
    logic [numSprites-1:0][missileW-1:0] field;
  } missileGrafU;

endpackage

`default_nettype wire

//--- hw/gtiaTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GTIA pixel path top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module gtiaTop import gtiaPkg::*; (
  input  logic Fphi0,
  input  logic rst,
  input  logic dListEnd,
  input  logic [anW-1:0] an,
  input  logic [1:0] numLines,
  input  logic [xW-1:0] width,
  input  logic [yW-1:0] height,
  input  logic [colorW-1:0] prior,
  input  logic [colorW-1:0] colBk,
  input  logic [colorW-1:0] colPf0,
  input  logic [colorW-1:0] colPf1,
  input  logic [colorW-1:0] colPf2,
  input  logic [colorW-1:0] colPf3,
  input  logic [colorW-1:0] colPm0,
  input  logic [colorW-1:0] colPm1,
  input  logic [colorW-1:0] colPm2,
  input  logic [colorW-1:0] colPm3,
  input  logic [7:0] hPosP0,
  input  logic [7:0] hPosP1,
  input  logic [7:0] hPosP2,
  input  logic [7:0] hPosP3,
  input  logic [7:0] hPosM0,
  input  logic [7:0] hPosM1,
  input  logic [7:0] hPosM2,
  input  logic [7:0] hPosM3,
  input  logic [playerW-1:0] grafP0,
  input  logic [playerW-1:0] grafP1,
  input  logic [playerW-1:0] grafP2,
  input  logic [playerW-1:0] grafP3,
  input  logic [colorW-1:0] grafM,
  output logic [colorW-1:0] dBufData,
  output logic [addrW-1:0] dBufAddr,
  output logic dBufWriteEn,
  output logic hblank,
  output logic vblank
);

  logic [xW-1:0] x;
  logic [yW-1:0] y;
  logic advance;
  logic [numSprites-1:0] playerHit;
  logic [numSprites-1:0] missileHit;

  playfieldIf pf ();

  rasterCounter raster (
    .Fphi0(Fphi0),
    .rst(rst),
    .dListEnd(dListEnd),
    .advance(advance),
    .numLines(numLines),
    .width(width),
    .height(height),
    .x(x),
    .y(y),
    .hblank(hblank),
    .vblank(vblank)
  );

  playfieldSelect pfSel (
    .Fphi0(Fphi0),
    .rst(rst),
    .an(an),
    .prior(prior),
    .colBk(colBk),
    .colPf0(colPf0),
    .colPf1(colPf1),
    .colPf2(colPf2),
    .colPf3(colPf3),
    .x(x),
    .y(y),
    .advance(advance),
    .pf(pf.src)
  );

  // Missile byte split into its four patterns here
  spriteUnit sprites (
    .Fphi0(Fphi0),
    .rst(rst),
    .x(x),
    .hPosP0(hPosP0),
    .hPosP1(hPosP1),
    .hPosP2(hPosP2),
    .hPosP3(hPosP3),
    .hPosM0(hPosM0),
    .hPosM1(hPosM1),
    .hPosM2(hPosM2),
    .hPosM3(hPosM3),
    .grafP0(grafP0),
    .grafP1(grafP1),
    .grafP2(grafP2),
    .grafP3(grafP3),
    .grafM(missileGrafU'(grafM)),
    .playerHit(playerHit),
    .missileHit(missileHit)
  );

  priorityMixer mixer (
    .Fphi0(Fphi0),
    .rst(rst),
    .prior(prior),
    .colPm0(colPm0),
    .colPm1(colPm1),
    .colPm2(colPm2),
    .colPm3(colPm3),
    .playerHit(playerHit),
    .missileHit(missileHit),
    .pf(pf.sink),
    .dBufData(dBufData),
    .dBufAddr(dBufAddr),
    .dBufWriteEn(dBufWriteEn)
  );

endmodule

`default_nettype wire

//--- hw/playfieldIf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Playfield pixel link
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

interface playfieldIf import gtiaPkg::*; ();

  // One registered pixel, present while valid is high
  logic valid;
  logic [colorW-1:0] baseColor;
  logic [anW-1:0] baseClass;
  logic [xW-1:0] x;
  logic [yW-1:0] y;

  modport src (output valid, output baseColor, output baseClass, output x, output y);

  modport sink (input valid, input baseColor, input baseClass, input x, input y);

endinterface

`default_nettype wire

//--- hw/playfieldSelect.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Playfield color select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module playfieldSelect import gtiaPkg::*; (
  input  logic Fphi0,
  input  logic rst,
  input  logic [anW-1:0] an,
  input  logic [colorW-1:0] prior,
  input  logic [colorW-1:0] colBk,
  input  logic [colorW-1:0] colPf0,
  input  logic [colorW-1:0] colPf1,
  input  logic [colorW-1:0] colPf2,
  input  logic [colorW-1:0] colPf3,
  input  logic [xW-1:0] x,
  input  logic [yW-1:0] y,
  output logic advance,
  playfieldIf.src pf
);

  logic accept;

  // Codes below anBackground carry no pixel
  assign accept = (prior[7:6] == modeNormal) && (an >= anBackground);
  assign advance = accept;

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      pf.valid <= 1'b0;
      pf.baseColor <= '0;
    end else begin
      pf.valid <= accept;
      if (accept) begin
        case (an)
          anBackground: pf.baseColor <= colBk;
          anLum1Col2: pf.baseColor <= {colPf2[7:4], colPf1[3:0]};
          anPlayfield0: pf.baseColor <= colPf0;
          anPlayfield1: pf.baseColor <= colPf1;
          anPlayfield2: pf.baseColor <= colPf2;
          anPlayfield3: pf.baseColor <= colPf3;
          // Vsync and hblank repeat the last color
          default: pf.baseColor <= pf.baseColor;
        endcase
      end
    end
  end

  // Pixel class and position travel with the color
  always_ff @(posedge Fphi0) begin
    if (accept) begin
      pf.baseClass <= an;
      pf.x <= x;
      pf.y <= y;
    end
  end

endmodule

`default_nettype wire

//--- hw/priorityMixer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Priority mixer and buffer write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module priorityMixer import gtiaPkg::*; (
  input  logic Fphi0,
  input  logic rst,
  input  logic [colorW-1:0] prior,
  input  logic [colorW-1:0] colPm0,
  input  logic [colorW-1:0] colPm1,
  input  logic [colorW-1:0] colPm2,
  input  logic [colorW-1:0] colPm3,
  input  logic [numSprites-1:0] playerHit,
  input  logic [numSprites-1:0] missileHit,
  playfieldIf.sink pf,
  output logic [colorW-1:0] dBufData,
  output logic [addrW-1:0] dBufAddr,
  output logic dBufWriteEn
);

  logic [numSprites-1:0] active;
  logic [numSprites-1:0][colorW-1:0] pmColor;
  logic classLow;
  logic classHigh;
  logic [colorW-1:0] mixColor;

  // Sprite color, merged with the playfield when the player overlaps it
  function automatic logic [colorW-1:0] pairColor(input logic [colorW-1:0] pm,
                                                  input logic [colorW-1:0] base,
                                                  input logic merge);
    pairColor = merge ? (pm | base) : pm;
  endfunction

  assign active = playerHit | missileHit;
  assign pmColor = {colPm3, colPm2, colPm1, colPm0};
  assign classLow = (pf.baseClass == anPlayfield0) || (pf.baseClass == anPlayfield1);
  assign classHigh = (pf.baseClass == anPlayfield2) || (pf.baseClass == anPlayfield3);

  always_comb begin
    mixColor = pf.baseColor;
    case (prior[3:0])
      prioPfOverLow: begin
        if (active[0]) begin
          mixColor = pairColor(colPm0, pf.baseColor, playerHit[0] && classLow);
        end else if (active[1]) begin
          mixColor = pairColor(colPm1, pf.baseColor, playerHit[1] && classLow);
        end else if (classLow) begin
          mixColor = pf.baseColor;
        end else if (active[2]) begin
          mixColor = pairColor(colPm2, pf.baseColor, playerHit[2] && classHigh);
        end else if (active[3]) begin
          mixColor = pairColor(colPm3, pf.baseColor, playerHit[3] && classHigh);
        end
      end
      default: begin
        // Lowest active pair wins over every playfield
        for (int n = numSprites - 1; n >= 0; n--) begin
          if (active[n]) begin
            mixColor = pmColor[n];
          end
        end
      end
    endcase
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      dBufWriteEn <= 1'b0;
    end else begin
      dBufWriteEn <= pf.valid;
    end
  end

  always_ff @(posedge Fphi0) begin
    dBufData <= mixColor;
    dBufAddr <= addrW'(pf.y) * addrW'(screenStride) + addrW'(pf.x);
  end

  // Writes stay inside the buffer rows
  writeInBuffer: assert property (@(posedge Fphi0) disable iff (rst)
    dBufWriteEn |-> (dBufAddr < addrW'(screenStride << yW)));

endmodule

`default_nettype wire

//--- hw/rasterCounter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster position counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module rasterCounter import gtiaPkg::*; (
  input  logic Fphi0,
  input  logic rst,
  input  logic dListEnd,
  input  logic advance,
  input  logic [1:0] numLines,
  input  logic [xW-1:0] width,
  input  logic [yW-1:0] height,
  output logic [xW-1:0] x,
  output logic [yW-1:0] y,
  output logic hblank,
  output logic vblank
);

  logic lastX;
  logic lastY;

  // End of line and end of frame, robust to a shrinking window
  assign lastX = (x >= width - xW'(1));
  assign lastY = (y >= height - yW'(1));

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      x <= '0;
      y <= '0;
      hblank <= 1'b0;
      vblank <= 1'b0;
    end else begin
      // Blank strobes last one cycle
      hblank <= 1'b0;
      vblank <= 1'b0;
      if (dListEnd) begin
        x <= '0;
        y <= '0;
      end else if (advance) begin
        if (numLines == lineDouble) begin
          if (!y[0]) begin
            // Upper scan line to the lower one, same x
            y <= y + yW'(1);
          end else if (lastX) begin
            // Pair row done
            x <= '0;
            hblank <= 1'b1;
            if (lastY) begin
              y <= '0;
            end else begin
              y <= y + yW'(1);
            end
          end else begin
            // Lower scan line back up, one pixel right
            x <= x + xW'(1);
            y <= y - yW'(1);
          end
        end else begin
          // Single scan line per mode line
          if (!lastX) begin
            x <= x + xW'(1);
          end else begin
            x <= '0;
            hblank <= 1'b1;
            if (lastY) begin
              y <= '0;
              vblank <= 1'b1;
            end else begin
              y <= y + yW'(1);
            end
          end
        end
      end
    end
  end

  // Every step or restart lands inside the window
  stepInWindow: assert property (@(posedge Fphi0) disable iff (rst)
    (advance || dListEnd) |=> (x < width) && (y < height));

endmodule

`default_nettype wire

//--- hw/spriteUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Player and missile coverage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module spriteUnit import gtiaPkg::*; (
  input  logic Fphi0,
  input  logic rst,
  input  logic [xW-1:0] x,
  input  logic [7:0] hPosP0,
  input  logic [7:0] hPosP1,
  input  logic [7:0] hPosP2,
  input  logic [7:0] hPosP3,
  input  logic [7:0] hPosM0,
  input  logic [7:0] hPosM1,
  input  logic [7:0] hPosM2,
  input  logic [7:0] hPosM3,
  input  logic [playerW-1:0] grafP0,
  input  logic [playerW-1:0] grafP1,
  input  logic [playerW-1:0] grafP2,
  input  logic [playerW-1:0] grafP3,
  input  missileGrafU grafM,
  output logic [numSprites-1:0] playerHit,
  output logic [numSprites-1:0] missileHit
);

  logic [7:0] hPos;
  logic [numSprites-1:0][7:0] playerPos;
  logic [numSprites-1:0][7:0] missilePos;
  logic [numSprites-1:0][playerW-1:0] playerGraf;
  logic [numSprites-1:0] playerNext;
  logic [numSprites-1:0] missileNext;

  // Pattern bit under pos for a sprite of size pixels starting at start
  function automatic logic coverBit(input logic [7:0] pos, input logic [7:0] start,
                                    input logic [playerW-1:0] pattern,
                                    input logic [3:0] size);
    logic [8:0] lo;
    logic [8:0] hi;
    logic [7:0] offs;
    lo = {1'b0, start};
    hi = lo + {5'd0, size};
    offs = pos - start;
    if (({1'b0, pos} >= lo) && ({1'b0, pos} < hi)) begin
      coverBit = pattern[3'(size - 4'd1 - offs[3:0])];
    end else begin
      coverBit = 1'b0;
    end
  endfunction

  // Two raster pixels per color clock
  assign hPos = x[8:1] + hPosOffset;

  assign playerPos = {hPosP3, hPosP2, hPosP1, hPosP0};
  assign missilePos = {hPosM3, hPosM2, hPosM1, hPosM0};
  assign playerGraf = {grafP3, grafP2, grafP1, grafP0};

  always_comb begin
    for (int n = 0; n < numSprites; n++) begin
      playerNext[n] = coverBit(hPos, playerPos[n], playerGraf[n], 4'(playerW));
      missileNext[n] = coverBit(hPos, missilePos[n],
                                playerW'(grafM.field[n]), 4'(missileW));
    end
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      playerHit <= '0;
      missileHit <= '0;
    end else begin
      playerHit <= playerNext;
      missileHit <= missileNext;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the GTIA pixel path testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert --timescale 1ns/10ps \
  --top-module gtiaTb -f files.f -o gtiaSim
./obj_dir/gtiaSim > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation PASSED" sim.log; then
  echo "run.sh: pass"
  exit 0
fi
echo "run.sh: fail"
exit 1

//--- sim/gtiaStimulus.txt
# set <register> <index> <hex value>
# pix <an hex> <dListEnd> <expected color hex> <repeat count>
# Playfield decoding in an 8 x 4 single-line window
set width 0 8
set height 0 4
set colBk 0 02
set colPf 0 14
set colPf 1 26
set colPf 2 b8
set colPf 3 4a
pix 8 0 02 1
pix c 0 14 1
pix d 0 26 1
pix e 0 b8 1
pix f 0 4a 1
pix b 0 b6 1
pix 9 0 b6 1
pix 3 0 00 2
pix a 0 b6 1
# Single-line raster in a 3 x 2 window
set width 0 3
set height 0 2
pix 0 1 00 1
pix c 0 14 7
# Double-line raster in a 2 x 4 window, restarted mid frame
set numLines 0 1
set width 0 2
set height 0 4
pix 0 1 00 1
pix d 0 26 6
pix d 1 26 1
pix d 0 26 1
# Player 0 and missile 3 over the background, row 0
set numLines 0 0
set width 0 c
set height 0 2
set colPm 0 44
set colPm 2 80
set colPm 3 a6
set hPosP 0 32
set grafP 0 90
set hPosM 3 33
set grafM 0 80
pix 0 1 00 1
pix 8 0 02 4
pix 8 0 44 2
pix 8 0 a6 2
pix 8 0 02 2
pix 8 0 44 2
# Priority against playfields, row 1
set hPosP 2 30
set grafP 2 c0
pix c 0 14 1
pix f 0 ca 1
pix 8 0 80 1
pix d 0 26 1
pix c 0 54 1
pix f 0 44 1
pix f 0 a6 1
set prior 0 01
pix c 0 a6 1
pix d 0 26 1
pix e 0 b8 1
pix c 0 44 1
pix f 0 44 1
# Non-normal mode writes nothing and holds the raster
set prior 0 40
pix c 0 00 3
set prior 0 00
pix c 0 14 1
pix 8 0 80 1

//--- sim/gtiaTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GTIA pixel path testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module gtiaTb import gtiaPkg::*; ();

  localparam int writeTimeout = 8;

  logic Fphi0;
  logic rst;
  logic dListEnd;
  logic [anW-1:0] an;
  logic [1:0] numLines;
  logic [xW-1:0] width;
  logic [yW-1:0] height;
  logic [colorW-1:0] prior;
  logic [colorW-1:0] colBk;
  logic [colorW-1:0] colPf [4];
  logic [colorW-1:0] colPm [4];
  logic [7:0] hPosP [4];
  logic [7:0] hPosM [4];
  logic [playerW-1:0] grafP [4];
  logic [colorW-1:0] grafM;
  logic [colorW-1:0] dBufData;
  logic [addrW-1:0] dBufAddr;
  logic dBufWriteEn;
  logic hblank;
  logic vblank;

  // Raster position that the next accepted pixel takes
  int unsigned modelX;
  int unsigned modelY;
  int unsigned writes;

  gtiaTop DUT (
    .Fphi0(Fphi0), .rst(rst), .dListEnd(dListEnd), .an(an),
    .numLines(numLines), .width(width), .height(height), .prior(prior),
    .colBk(colBk), .colPf0(colPf[0]), .colPf1(colPf[1]), .colPf2(colPf[2]),
    .colPf3(colPf[3]), .colPm0(colPm[0]), .colPm1(colPm[1]), .colPm2(colPm[2]),
    .colPm3(colPm[3]), .hPosP0(hPosP[0]), .hPosP1(hPosP[1]), .hPosP2(hPosP[2]),
    .hPosP3(hPosP[3]), .hPosM0(hPosM[0]), .hPosM1(hPosM[1]), .hPosM2(hPosM[2]),
    .hPosM3(hPosM[3]), .grafP0(grafP[0]), .grafP1(grafP[1]), .grafP2(grafP[2]),
    .grafP3(grafP[3]), .grafM(grafM), .dBufData(dBufData), .dBufAddr(dBufAddr),
    .dBufWriteEn(dBufWriteEn), .hblank(hblank), .vblank(vblank)
  );

  initial begin
    Fphi0 = 1'b0;
    forever #50 Fphi0 = ~Fphi0;
  end

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkColor(input string name, input logic [colorW-1:0] got,
                            input logic [colorW-1:0] want);
    if (got !== want) begin
      failRun($sformatf("mismatch %s: got 0x%02h, expected 0x%02h", name, got, want));
    end
  endtask

  task automatic checkAddr(input string name, input logic [addrW-1:0] got,
                           input logic [addrW-1:0] want);
    if (got !== want) begin
      failRun($sformatf("mismatch %s: got 0x%05h, expected 0x%05h", name, got, want));
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic want);
    if (got !== want) begin
      failRun($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, want));
    end
  endtask

  // Counter rules: restart wins, then single or double line stepping
  task automatic stepRaster(input logic accepted, input logic restart,
                            output logic expHb, output logic expVb);
    expHb = 1'b0;
    expVb = 1'b0;
    if (restart) begin
      modelX = 0;
      modelY = 0;
    end else if (accepted) begin
      if ((numLines == lineDouble) && (modelY % 2 == 0)) begin
        modelY = modelY + 1;
      end else if (modelX + 1 < int'(width)) begin
        modelX = modelX + 1;
        if (numLines == lineDouble) begin
          modelY = modelY - 1;
        end
      end else begin
        modelX = 0;
        expHb = 1'b1;
        if (modelY + 1 < int'(height)) begin
          modelY = modelY + 1;
        end else begin
          modelY = 0;
          expVb = (numLines != lineDouble);
        end
      end
    end
  endtask

  // One pixel in, then its write one cycle later or no write at all
  task automatic runPixel(input logic [anW-1:0] code, input logic restart,
                          input logic [colorW-1:0] wantColor);
    logic accepted;
    logic expHb;
    logic expVb;
    logic [addrW-1:0] wantAddr;
    int waited;
    accepted = (prior[7:6] == modeNormal) && (code >= anBackground);
    wantAddr = addrW'(modelY * screenStride + modelX);
    stepRaster(accepted, restart, expHb, expVb);
    an = code;
    dListEnd = restart;
    @(posedge Fphi0);
    @(negedge Fphi0);
    an = anIdle;
    dListEnd = 1'b0;
    checkFlag("hblank", hblank, expHb);
    checkFlag("vblank", vblank, expVb);
    checkFlag("dBufWriteEn", dBufWriteEn, 1'b0);
    if (accepted) begin
      waited = 0;
      while (!dBufWriteEn && (waited < writeTimeout)) begin
        @(negedge Fphi0);
        waited++;
      end
      if (!dBufWriteEn) begin
        failRun("timed out waiting for a display buffer write");
      end
      if (waited != 1) begin
        failRun($sformatf("buffer write came %0d cycles after its pixel, not 1", waited));
      end
      checkColor("dBufData", dBufData, wantColor);
      checkAddr("dBufAddr", dBufAddr, wantAddr);
      checkFlag("hblank", hblank, 1'b0);
      writes++;
    end else begin
      @(negedge Fphi0);
      checkFlag("dBufWriteEn", dBufWriteEn, 1'b0);
    end
  endtask

  task automatic setReg(input string name, input int idx, input logic [31:0] value);
    if ((idx < 0) || (idx > 3)) begin
      failRun($sformatf("register index %0d out of range in the stimulus file", idx));
    end
    case (name)
      "prior": prior = value[7:0];
      "colBk": colBk = value[7:0];
      "colPf": colPf[idx[1:0]] = value[7:0];
      "colPm": colPm[idx[1:0]] = value[7:0];
      "hPosP": hPosP[idx[1:0]] = value[7:0];
      "hPosM": hPosM[idx[1:0]] = value[7:0];
      "grafP": grafP[idx[1:0]] = value[7:0];
      "grafM": grafM = value[7:0];
      "width": width = value[xW-1:0];
      "height": height = value[yW-1:0];
      "numLines": numLines = value[1:0];
      default: failRun({"unknown register name in the stimulus file: ", name});
    endcase
  endtask

  initial begin
    int fd;
    int count;
    int idx;
    string line;
    string cmd;
    string name;
    logic [31:0] value;
    logic [31:0] code;
    logic [31:0] restart;
    logic [31:0] color;
    logic [31:0] repeats;
    rst = 1'b1;
    dListEnd = 1'b0;
    an = anIdle;
    numLines = lineSingle;
    width = 9'd8;
    height = 8'd4;
    prior = 8'h00;
    colBk = 8'h00;
    grafM = 8'h00;
    for (int n = 0; n < 4; n++) begin
      colPf[n] = 8'h00;
      colPm[n] = 8'h00;
      hPosP[n] = 8'h00;
      hPosM[n] = 8'h00;
      grafP[n] = 8'h00;
    end
    modelX = 0;
    modelY = 0;
    writes = 0;
    repeat (3) @(posedge Fphi0);
    @(negedge Fphi0);
    rst = 1'b0;
    checkFlag("dBufWriteEn", dBufWriteEn, 1'b0);
    checkFlag("hblank", hblank, 1'b0);
    checkFlag("vblank", vblank, 1'b0);

    fd = $fopen("sim/gtiaStimulus.txt", "r");
    if (fd == 0) begin
      failRun("cannot open the stimulus file sim/gtiaStimulus.txt");
    end
    while ($fgets(line, fd) != 0) begin
      count = $sscanf(line, "%s", cmd);
      if ((count != 1) || (cmd == "#")) begin
        // Blank or comment line
      end else if (cmd == "set") begin
        count = $sscanf(line, "%s %s %d %h", cmd, name, idx, value);
        if (count != 4) begin
          failRun({"malformed register line in the stimulus file: ", line});
        end
        setReg(name, idx, value);
      end else if (cmd == "pix") begin
        count = $sscanf(line, "%s %h %h %h %d", cmd, code, restart, color, repeats);
        if (count != 5) begin
          failRun({"malformed pixel line in the stimulus file: ", line});
        end
        for (int r = 0; r < int'(repeats); r++) begin
          runPixel(code[anW-1:0], restart[0], color[colorW-1:0]);
        end
      end else begin
        failRun({"unknown line in the stimulus file: ", line});
      end
    end
    $fclose(fd);

    if (writes == 0) begin
      failRun("the stimulus file produced no buffer writes");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
